/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int WORD_W = 16;
	localparam int ADDR_W = 8;
	localparam int NREG = 4;

	// ----------------------------------------
	// Instruction word fields
	// ----------------------------------------
	localparam int OP_MSB = 15;
	localparam int OP_LSB = 12;
	localparam int REG_MSB = 11;
	localparam int REG_LSB = 10;
	// Bits 9..8 carry nothing
	localparam int ADDR_MSB = 7;
	localparam int ADDR_LSB = 0;

	typedef enum logic [3:0] {
		OP_LW  = 4'd0,
		OP_SW  = 4'd1,
		OP_ADD = 4'd2,
		OP_SUB = 4'd3,
		OP_AND = 4'd4,
		OP_JMP = 4'd5,
		OP_JZ  = 4'd6,
		OP_HLT = 4'd7
	} opcode_t;

	// Control sequencer phases
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_MEM,
		ST_EXEC
	} pm_state_t;

endpackage

`default_nettype wire

/* verilog/pm.sv */
`timescale 1ns/10ps
`default_nettype none

module pm (
	input  logic             __clk,
	input  logic             arst_n,
	input  logic             start_pulse,
	input  logic             stop_req,
	input  cpu_pkg::opcode_t opcode,
	input  logic             reg_zero,
	input  logic             bus_gnt,
	input  logic             bus_rdy,
	output logic             run,
	output logic             ir_load,
	output logic             ic_load,
	output logic             ic_inc,
	output logic             reg_write,
	output logic             bus_req,
	output logic             bus_we,
	output logic             addr_sel
);

	cpu_pkg::pm_state_t state;
	logic stop_pend;
	logic mem_op;
	logic halt_now;

	// Instructions that need an operand cycle on the bus
	assign mem_op = opcode inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW, cpu_pkg::OP_ADD,
		cpu_pkg::OP_SUB, cpu_pkg::OP_AND};
	assign halt_now = (opcode == cpu_pkg::OP_HLT) || stop_pend || stop_req;

	// Operand address only during the MEM phase
	assign addr_sel = (state == cpu_pkg::ST_MEM);
	assign bus_we = (state == cpu_pkg::ST_MEM) && (opcode == cpu_pkg::OP_SW);

	// IR and IC advance together on the fetch data strobe
	assign ir_load = (state == cpu_pkg::ST_FETCH) && bus_rdy;
	assign ic_inc = ir_load;
	// Register update straight off the read data
	assign reg_write = (state == cpu_pkg::ST_MEM) && bus_rdy && (opcode != cpu_pkg::OP_SW);
	assign ic_load = (state == cpu_pkg::ST_EXEC) && ((opcode == cpu_pkg::OP_JMP) ||
		((opcode == cpu_pkg::OP_JZ) && reg_zero));

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_pkg::ST_IDLE;
			run <= 1'b0;
			stop_pend <= 1'b0;
			bus_req <= 1'b0;
		end else begin
			// Stop is honoured only at an instruction boundary
			if (stop_req && run)
				stop_pend <= 1'b1;
			case (state)
				cpu_pkg::ST_IDLE: begin
					if (start_pulse) begin
						state <= cpu_pkg::ST_FETCH;
						run <= 1'b1;
						bus_req <= 1'b1;
					end
				end
				cpu_pkg::ST_FETCH: begin
					if (bus_gnt)
						bus_req <= 1'b0;
					if (bus_rdy)
						state <= cpu_pkg::ST_DECODE;
				end
				cpu_pkg::ST_DECODE: begin
					if (mem_op) begin
						state <= cpu_pkg::ST_MEM;
						bus_req <= 1'b1;
					end else begin
						state <= cpu_pkg::ST_EXEC;
					end
				end
				cpu_pkg::ST_MEM: begin
					if (bus_gnt)
						bus_req <= 1'b0;
					if (bus_rdy)
						state <= cpu_pkg::ST_EXEC;
				end
				cpu_pkg::ST_EXEC: begin
					if (halt_now) begin
						state <= cpu_pkg::ST_IDLE;
						run <= 1'b0;
						stop_pend <= 1'b0;
					end else begin
						state <= cpu_pkg::ST_FETCH;
						bus_req <= 1'b1;
					end
				end
				default: state <= cpu_pkg::ST_IDLE;
			endcase
		end
	end

	a_req_while_run: assert property (@(posedge __clk) disable iff (!arst_n)
		$rose(bus_req) |-> run)
		else $error("bus request raised with CPU stopped");

endmodule

`default_nettype wire

/* verilog/pd.sv */
`timescale 1ns/10ps
`default_nettype none

module pd (
	input  logic                              __clk,
	input  logic                              arst_n,
	input  logic                              ir_load,
	input  logic [cpu_pkg::WORD_W-1:0]        bus_rdata,
	output cpu_pkg::opcode_t                  opcode,
	output logic [$clog2(cpu_pkg::NREG)-1:0]  reg_sel,
	output logic [cpu_pkg::ADDR_W-1:0]        op_addr
);

	logic [cpu_pkg::WORD_W-1:0] ir;
	logic [cpu_pkg::OP_MSB-cpu_pkg::OP_LSB:0] op_field;

	// Instruction register
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n)
			ir <= '0;
		else if (ir_load)
			ir <= bus_rdata;
	end

	assign op_field = ir[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB];

	// Codes 8..15 fold onto HLT
	assign opcode = (op_field > 4'd7) ? cpu_pkg::OP_HLT : cpu_pkg::opcode_t'(op_field);
	assign reg_sel = ir[cpu_pkg::REG_MSB:cpu_pkg::REG_LSB];
	assign op_addr = ir[cpu_pkg::ADDR_MSB:cpu_pkg::ADDR_LSB];

endmodule

`default_nettype wire

/* verilog/pa.sv */
`timescale 1ns/10ps
`default_nettype none

module pa (
	input  logic                              __clk,
	input  logic                              arst_n,
	input  logic                              ic_load,
	input  logic                              ic_inc,
	input  logic                              reg_write,
	input  logic                              addr_sel,
	input  logic                              start_pulse,
	input  logic [cpu_pkg::ADDR_W-1:0]        sw_addr,
	input  cpu_pkg::opcode_t                  opcode,
	input  logic [$clog2(cpu_pkg::NREG)-1:0]  reg_sel,
	input  logic [cpu_pkg::ADDR_W-1:0]        op_addr,
	input  logic [cpu_pkg::WORD_W-1:0]        bus_rdata,
	output logic [cpu_pkg::ADDR_W-1:0]        bus_addr,
	output logic [cpu_pkg::WORD_W-1:0]        bus_wdata,
	output logic                              reg_zero
);

	logic [cpu_pkg::WORD_W-1:0] regs [cpu_pkg::NREG];
	logic [cpu_pkg::ADDR_W-1:0] ic;
	logic [cpu_pkg::WORD_W-1:0] cur;
	logic [cpu_pkg::WORD_W-1:0] alu;

	// ----------------------------------------
	// Instruction counter
	// ----------------------------------------
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n)
			ic <= '0;
		else if (start_pulse)
			ic <= sw_addr;
		else if (ic_load)
			ic <= op_addr;
		else if (ic_inc)
			ic <= ic + 1'b1;
	end

	// ----------------------------------------
	// Register file and ALU
	// ----------------------------------------
	assign cur = regs[reg_sel];

	// LW passes memory data through, wraps mod 2^16 otherwise
	always_comb begin
		case (opcode)
			cpu_pkg::OP_ADD: alu = cur + bus_rdata;
			cpu_pkg::OP_SUB: alu = cur - bus_rdata;
			cpu_pkg::OP_AND: alu = cur & bus_rdata;
			default:         alu = bus_rdata;
		endcase
	end

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < cpu_pkg::NREG; i++)
				regs[i] <= '0;
		end else if (reg_write) begin
			regs[reg_sel] <= alu;
		end
	end

	assign reg_zero = (cur == '0);

	// Bus side
	assign bus_addr = addr_sel ? op_addr : ic;
	assign bus_wdata = cur;

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu (
	input  logic                        __clk,
	input  logic                        arst_n,
	input  logic                        start_pulse,
	input  logic                        stop_req,
	input  logic [cpu_pkg::ADDR_W-1:0]  sw_addr,
	input  logic                        bus_gnt,
	input  logic                        bus_rdy,
	input  logic [cpu_pkg::WORD_W-1:0]  bus_rdata,
	output logic                        run,
	output logic                        bus_req,
	output logic                        bus_we,
	output logic [cpu_pkg::ADDR_W-1:0]  bus_addr,
	output logic [cpu_pkg::WORD_W-1:0]  bus_wdata
);

	// ----------------------------------------
	// PM control sequencer
	// ----------------------------------------
	cpu_pkg::opcode_t opcode;
	logic reg_zero, ir_load, ic_load, ic_inc, reg_write, addr_sel;

	pm u_pm (
		.__clk(__clk),
		.arst_n(arst_n),
		.start_pulse(start_pulse),
		.stop_req(stop_req),
		.opcode(opcode),
		.reg_zero(reg_zero),
		.bus_gnt(bus_gnt),
		.bus_rdy(bus_rdy),
		.run(run),
		.ir_load(ir_load),
		.ic_load(ic_load),
		.ic_inc(ic_inc),
		.reg_write(reg_write),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.addr_sel(addr_sel)
	);

	// ----------------------------------------
	// PD instruction decoder
	// ----------------------------------------
	logic [$clog2(cpu_pkg::NREG)-1:0] reg_sel;
	logic [cpu_pkg::ADDR_W-1:0] op_addr;

	pd u_pd (
		.__clk(__clk),
		.arst_n(arst_n),
		.ir_load(ir_load),
		.bus_rdata(bus_rdata),
		.opcode(opcode),
		.reg_sel(reg_sel),
		.op_addr(op_addr)
	);

	// ----------------------------------------
	// PA registers and arithmetic
	// ----------------------------------------
	pa u_pa (
		.__clk(__clk),
		.arst_n(arst_n),
		.ic_load(ic_load),
		.ic_inc(ic_inc),
		.reg_write(reg_write),
		.addr_sel(addr_sel),
		.start_pulse(start_pulse),
		.sw_addr(sw_addr),
		.opcode(opcode),
		.reg_sel(reg_sel),
		.op_addr(op_addr),
		.bus_rdata(bus_rdata),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.reg_zero(reg_zero)
	);

endmodule

`default_nettype wire

/* verilog/panel.sv */
`timescale 1ns/10ps
`default_nettype none

module panel (
	input  logic                        __clk,
	input  logic                        arst_n,
	input  logic                        panel_load,
	input  logic                        panel_fetch,
	input  logic                        panel_start,
	input  logic                        panel_stop,
	input  logic [cpu_pkg::ADDR_W-1:0]  sw_addr,
	input  logic [cpu_pkg::WORD_W-1:0]  sw_data,
	input  logic                        bus_gnt,
	input  logic                        bus_rdy,
	input  logic [cpu_pkg::WORD_W-1:0]  bus_rdata,
	output logic                        bus_req,
	output logic                        bus_we,
	output logic [cpu_pkg::ADDR_W-1:0]  bus_addr,
	output logic [cpu_pkg::WORD_W-1:0]  bus_wdata,
	output logic [cpu_pkg::WORD_W-1:0]  w,
	output logic                        busy,
	output logic                        start_pulse,
	output logic                        stop_req
);

	logic take_cmd;

	// Load wins over fetch if both arrive together
	assign take_cmd = !busy && (panel_load || panel_fetch);

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			bus_req <= 1'b0;
			bus_we <= 1'b0;
			w <= '0;
		end else begin
			if (take_cmd) begin
				busy <= 1'b1;
				bus_req <= 1'b1;
				bus_we <= panel_load;
			end else if (bus_gnt) begin
				bus_req <= 1'b0;
			end
			// Command done on the data strobe, reads land on the display
			if (bus_rdy) begin
				busy <= 1'b0;
				if (!bus_we)
					w <= bus_rdata;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (take_cmd) begin
			bus_addr <= sw_addr;
			bus_wdata <= sw_data;
		end
	end

	// Run control goes straight to the CPU, same cycle as sw_addr
	assign start_pulse = panel_start && !busy;
	assign stop_req = panel_stop && !busy;

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input  logic                        __clk,
	input  logic                        arst_n,
	input  logic                        p_req,
	input  logic                        p_we,
	input  logic [cpu_pkg::ADDR_W-1:0]  p_addr,
	input  logic [cpu_pkg::WORD_W-1:0]  p_wdata,
	input  logic                        c_req,
	input  logic                        c_we,
	input  logic [cpu_pkg::ADDR_W-1:0]  c_addr,
	input  logic [cpu_pkg::WORD_W-1:0]  c_wdata,
	input  logic [cpu_pkg::WORD_W-1:0]  mem_rdata,
	output logic                        p_gnt,
	output logic                        p_rdy,
	output logic                        c_gnt,
	output logic                        c_rdy,
	output logic [cpu_pkg::WORD_W-1:0]  p_rdata,
	output logic [cpu_pkg::WORD_W-1:0]  c_rdata,
	output logic                        mem_en,
	output logic                        mem_we,
	output logic [cpu_pkg::ADDR_W-1:0]  mem_addr,
	output logic [cpu_pkg::WORD_W-1:0]  mem_wdata
);

	logic inflight;
	logic owner_p;

	// Panel first, nothing while a cycle is open
	assign p_gnt = p_req && !inflight;
	assign c_gnt = c_req && !p_req && !inflight;

	assign mem_en = p_gnt || c_gnt;
	assign mem_we = p_gnt ? p_we : (c_gnt && c_we);
	assign mem_addr = p_gnt ? p_addr : c_addr;
	assign mem_wdata = p_gnt ? p_wdata : c_wdata;

	// Second half of the bus cycle, remember who started it
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			inflight <= 1'b0;
			owner_p <= 1'b0;
		end else begin
			inflight <= mem_en;
			owner_p <= p_gnt;
		end
	end

	assign p_rdy = inflight && owner_p;
	assign c_rdy = inflight && !owner_p;
	assign p_rdata = mem_rdata;
	assign c_rdata = mem_rdata;

	a_one_owner: assert property (@(posedge __clk) disable iff (!arst_n)
		!(p_gnt && c_gnt))
		else $error("both masters granted");

	a_no_overlap: assert property (@(posedge __clk) disable iff (!arst_n)
		(p_gnt || c_gnt) |=> !(p_gnt || c_gnt))
		else $error("grant during open bus cycle");

endmodule

`default_nettype wire

/* verilog/mem.sv */
`timescale 1ns/10ps
`default_nettype none

module mem (
	input  logic                        __clk,
	input  logic                        mem_en,
	input  logic                        mem_we,
	input  logic [cpu_pkg::ADDR_W-1:0]  mem_addr,
	input  logic [cpu_pkg::WORD_W-1:0]  mem_wdata,
	output logic [cpu_pkg::WORD_W-1:0]  mem_rdata
);

	logic [cpu_pkg::WORD_W-1:0] ram [0:(1 << cpu_pkg::ADDR_W)-1];

	// Registered read, old data on a write cycle
	always_ff @(posedge __clk) begin
		if (mem_en) begin
			if (mem_we)
				ram[mem_addr] <= mem_wdata;
			mem_rdata <= ram[mem_addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/mera_system.sv */
`timescale 1ns/10ps
`default_nettype none

module mera_system (
	input  logic                        __clk,
	input  logic                        arst_n,
	input  logic                        panel_load,
	input  logic                        panel_fetch,
	input  logic                        panel_start,
	input  logic                        panel_stop,
	input  logic [cpu_pkg::ADDR_W-1:0]  sw_addr,
	input  logic [cpu_pkg::WORD_W-1:0]  sw_data,
	output logic [cpu_pkg::WORD_W-1:0]  w,
	output logic                        run,
	output logic                        busy
);

	logic p_req, p_we, p_gnt, p_rdy;
	logic c_req, c_we, c_gnt, c_rdy;
	logic [cpu_pkg::ADDR_W-1:0] p_addr, c_addr, mem_addr;
	logic [cpu_pkg::WORD_W-1:0] p_wdata, c_wdata, p_rdata, c_rdata;
	logic [cpu_pkg::WORD_W-1:0] mem_wdata, mem_rdata;
	logic mem_en, mem_we;
	logic start_pulse, stop_req;

	cpu u_cpu (
		.__clk(__clk), .arst_n(arst_n),
		.start_pulse(start_pulse), .stop_req(stop_req), .sw_addr(sw_addr),
		.bus_gnt(c_gnt), .bus_rdy(c_rdy), .bus_rdata(c_rdata),
		.run(run), .bus_req(c_req), .bus_we(c_we),
		.bus_addr(c_addr), .bus_wdata(c_wdata)
	);

	panel u_panel (
		.__clk(__clk), .arst_n(arst_n),
		.panel_load(panel_load), .panel_fetch(panel_fetch),
		.panel_start(panel_start), .panel_stop(panel_stop),
		.sw_addr(sw_addr), .sw_data(sw_data),
		.bus_gnt(p_gnt), .bus_rdy(p_rdy), .bus_rdata(p_rdata),
		.bus_req(p_req), .bus_we(p_we), .bus_addr(p_addr), .bus_wdata(p_wdata),
		.w(w), .busy(busy), .start_pulse(start_pulse), .stop_req(stop_req)
	);

	bus_arbiter u_bus_arbiter (
		.__clk(__clk), .arst_n(arst_n),
		.p_req(p_req), .p_we(p_we), .p_addr(p_addr), .p_wdata(p_wdata),
		.c_req(c_req), .c_we(c_we), .c_addr(c_addr), .c_wdata(c_wdata),
		.mem_rdata(mem_rdata),
		.p_gnt(p_gnt), .p_rdy(p_rdy), .c_gnt(c_gnt), .c_rdy(c_rdy),
		.p_rdata(p_rdata), .c_rdata(c_rdata),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	mem u_mem (
		.__clk(__clk),
		.mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

/* bench/tb_mera_system.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mera_system;

	logic clk;
	logic arst_n;
	logic panel_load;
	logic panel_fetch;
	logic panel_start;
	logic panel_stop;
	logic [cpu_pkg::ADDR_W-1:0] sw_addr;
	logic [cpu_pkg::WORD_W-1:0] sw_data;
	logic [cpu_pkg::WORD_W-1:0] w;
	logic run;
	logic busy;

	// Scoreboard memory image and register file per the ISA
	logic [15:0] model_mem [0:255];
	logic [15:0] model_reg [0:3];
	logic [7:0] seen_addr [0:7];
	logic [15:0] exp_w;
	logic [7:0] chk_addr;
	logic chk_w;
	logic chk_rst;
	int errors;
	int err_mark;
	int passed;
	int failed;

	mera_system u_mera_system (
		.__clk(clk), .arst_n(arst_n),
		.panel_load(panel_load), .panel_fetch(panel_fetch),
		.panel_start(panel_start), .panel_stop(panel_stop),
		.sw_addr(sw_addr), .sw_data(sw_data),
		.w(w), .run(run), .busy(busy)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	a_reset_state: assert property (@(posedge clk) chk_rst |-> (!run && !busy && w == '0))
		else begin
			errors++;
			$display("ERR %0t: after reset run=%b busy=%b w=%h", $time, run, busy, w);
		end

	a_fetch_word: assert property (@(posedge clk) disable iff (!arst_n) chk_w |-> (w == exp_w))
		else begin
			errors++;
			$display("ERR %0t: fetch of %h shows %h, expected %h", $time, chk_addr, w, exp_w);
		end

	// CPU leaves idle only through a panel start
	a_run_on_start: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(run) |-> $past(panel_start))
		else begin
			errors++;
			$display("ERR %0t: run rose without a panel start", $time);
		end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [15:0] rand16();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic logic [15:0] instr(input logic [3:0] op, input logic [1:0] r,
		input logic [7:0] a);
		return {op, r, 2'b00, a};
	endfunction

	// Reference interpreter bounded to 64 steps so a loop program ends
	task automatic model_run(input logic [7:0] start);
		logic [7:0] pc;
		logic [15:0] ins;
		logic [15:0] opnd;
		logic [1:0] r;
		logic halted;
		int steps;
		pc = start;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 64) begin
			ins = model_mem[pc];
			pc = pc + 8'd1;
			r = ins[11:10];
			opnd = model_mem[ins[7:0]];
			case (ins[15:12])
				cpu_pkg::OP_LW:  model_reg[r] = opnd;
				cpu_pkg::OP_SW:  model_mem[ins[7:0]] = model_reg[r];
				cpu_pkg::OP_ADD: model_reg[r] = model_reg[r] + opnd;
				cpu_pkg::OP_SUB: model_reg[r] = model_reg[r] - opnd;
				cpu_pkg::OP_AND: model_reg[r] = model_reg[r] & opnd;
				cpu_pkg::OP_JMP: pc = ins[7:0];
				cpu_pkg::OP_JZ:  if (model_reg[r] == 16'd0) pc = ins[7:0];
				default:         halted = 1'b1;
			endcase
			steps++;
		end
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			errors++;
			$display("Timeout at %0t: panel command never finished", $time);
		end
	endtask

	task automatic wait_halt();
		int n;
		n = 0;
		@(negedge clk);
		while (run && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (run) begin
			errors++;
			$display("Timeout at %0t: CPU never stopped running", $time);
		end
	endtask

	task automatic load_word(input logic [7:0] a, input logic [15:0] d);
		@(posedge clk);
		panel_load <= 1'b1;
		sw_addr <= a;
		sw_data <= d;
		@(posedge clk);
		panel_load <= 1'b0;
		wait_not_busy();
		model_mem[a] = d;
	endtask

	task automatic fetch_check(input logic [7:0] a);
		@(posedge clk);
		panel_fetch <= 1'b1;
		sw_addr <= a;
		@(posedge clk);
		panel_fetch <= 1'b0;
		wait_not_busy();
		@(posedge clk);
		exp_w <= model_mem[a];
		chk_addr <= a;
		chk_w <= 1'b1;
		@(posedge clk);
		chk_w <= 1'b0;
		@(negedge clk);
	endtask

	task automatic start_cpu(input logic [7:0] a);
		@(posedge clk);
		panel_start <= 1'b1;
		sw_addr <= a;
		@(posedge clk);
		panel_start <= 1'b0;
	endtask

	task automatic stop_cpu();
		@(posedge clk);
		panel_stop <= 1'b1;
		@(posedge clk);
		panel_stop <= 1'b0;
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			passed++;
			$display("PASS  %s", name);
		end else begin
			failed++;
			$display("FAIL  %s", name);
		end
		err_mark = errors;
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [7:0] a;
		logic [15:0] d;
		void'($urandom(22361));
		errors = 0;
		err_mark = 0;
		passed = 0;
		failed = 0;
		arst_n = 1'b0;
		panel_load = 1'b0;
		panel_fetch = 1'b0;
		panel_start = 1'b0;
		panel_stop = 1'b0;
		sw_addr = '0;
		sw_data = '0;
		exp_w = '0;
		chk_addr = '0;
		chk_w = 1'b0;
		chk_rst = 1'b0;
		for (int i = 0; i < 4; i++)
			model_reg[i] = '0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		@(posedge clk);
		chk_rst <= 1'b1;
		@(posedge clk);
		chk_rst <= 1'b0;
		@(negedge clk);
		end_test("reset state");

		// Data words kept clear of program and operand areas
		for (int i = 0; i < 8; i++) begin
			d = rand16();
			a = {2'b11, d[5:0]};
			seen_addr[i] = a;
			load_word(a, rand16());
		end
		for (int i = 0; i < 8; i++)
			fetch_check(seen_addr[i]);
		end_test("panel load and fetch");

		load_word(8'h80, rand16());
		load_word(8'h81, rand16());
		load_word(8'h82, rand16());
		load_word(8'h83, rand16());
		load_word(8'h84, 16'h0000);
		load_word(8'h10, instr(cpu_pkg::OP_LW, 2'd2, 8'h80));
		load_word(8'h11, instr(cpu_pkg::OP_ADD, 2'd2, 8'h81));
		load_word(8'h12, instr(cpu_pkg::OP_SUB, 2'd2, 8'h82));
		load_word(8'h13, instr(cpu_pkg::OP_AND, 2'd2, 8'h83));
		load_word(8'h14, instr(cpu_pkg::OP_SW, 2'd2, 8'h84));
		load_word(8'h15, instr(cpu_pkg::OP_HLT, 2'd0, 8'h00));
		start_cpu(8'h10);
		wait_halt();
		model_run(8'h10);
		fetch_check(8'h84);
		end_test("arithmetic program");

		// Taken path stores at 8B and fall-through at 8A
		load_word(8'h20, instr(cpu_pkg::OP_LW, 2'd3, 8'h89));
		load_word(8'h21, instr(cpu_pkg::OP_LW, 2'd2, 8'h88));
		load_word(8'h22, instr(cpu_pkg::OP_JZ, 2'd2, 8'h25));
		load_word(8'h23, instr(cpu_pkg::OP_SW, 2'd3, 8'h8A));
		load_word(8'h24, instr(cpu_pkg::OP_HLT, 2'd0, 8'h00));
		load_word(8'h25, instr(cpu_pkg::OP_SW, 2'd3, 8'h8B));
		load_word(8'h26, instr(cpu_pkg::OP_HLT, 2'd0, 8'h00));
		for (int k = 0; k < 2; k++) begin
			d = rand16();
			load_word(8'h88, (k == 0) ? 16'h0000 : (d | 16'h0001));
			load_word(8'h89, rand16() | 16'h8000);
			load_word(8'h8A, 16'h0000);
			load_word(8'h8B, 16'h0000);
			start_cpu(8'h20);
			wait_halt();
			model_run(8'h20);
			fetch_check(8'h8A);
			fetch_check(8'h8B);
		end
		end_test("conditional jump");

		load_word(8'h90, rand16());
		load_word(8'h91, rand16());
		load_word(8'h92, 16'h0000);
		load_word(8'h50, instr(cpu_pkg::OP_LW, 2'd1, 8'h90));
		load_word(8'h51, instr(cpu_pkg::OP_ADD, 2'd1, 8'h91));
		load_word(8'h52, instr(cpu_pkg::OP_SW, 2'd1, 8'h92));
		load_word(8'h53, instr(cpu_pkg::OP_JMP, 2'd0, 8'h50));
		start_cpu(8'h50);
		// Panel traffic competes with the looping CPU
		for (int i = 0; i < 16; i++)
			fetch_check(seen_addr[i % 8]);
		stop_cpu();
		wait_halt();
		model_run(8'h50);
		fetch_check(8'h92);
		end_test("arbitration under load");

		d = rand16();
		load_word(8'h98, rand16() | 16'h0001);
		load_word(8'h99, 16'h0000);
		load_word(8'h40, instr(cpu_pkg::OP_LW, 2'd1, 8'h98));
		load_word(8'h41, instr({1'b1, d[2:0]}, 2'd1, 8'h99));
		load_word(8'h42, instr(cpu_pkg::OP_SW, 2'd1, 8'h99));
		load_word(8'h43, instr(cpu_pkg::OP_HLT, 2'd0, 8'h00));
		start_cpu(8'h40);
		wait_halt();
		model_run(8'h40);
		fetch_check(8'h99);
		end_test("unused opcode");

		$display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mera_system.f */
verilog/cpu_pkg.sv
verilog/pm.sv
verilog/pd.sv
verilog/pa.sv
verilog/cpu.sv
verilog/panel.sv
verilog/bus_arbiter.sv
verilog/mem.sv
verilog/mera_system.sv
bench/tb_mera_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mera_system \
	-f mera_system.f -o vsim_mera_system
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vsim_mera_system > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
